// ==== hdl/bus_map_pkg.sv ====
package bus_map_pkg;

    // access port
    localparam int addr_width   = 32;
    localparam int region_count = 4;

    // slave windows, one entry per region, lowest first
    localparam logic [0:region_count-1][addr_width-1:0] start_addr = {
        32'h0000_0000,
        32'h1000_0000,
        32'h2000_0000,
        32'h3000_0000
    };

    localparam logic [0:region_count-1][addr_width-1:0] end_addr = {
        32'h0FFF_FFFF,
        32'h1FFF_FFFF,
        32'h2FFF_FFFF,
        32'h3FFF_FFFF
    };

    // 0..3 is a region, 4 is a miss
    typedef logic [2:0] region_t;

    localparam region_t miss_code = 3'd4;

    // access counters wrap at 256
    typedef logic [7:0] count_t;

endpackage

// ==== hdl/panel_pkg.sv ====
package panel_pkg;

    localparam int page_count = 16;

    typedef logic [3:0] page_t;
    typedef logic [7:0] led_byte_t;

    // stable samples needed before a button level is taken
    localparam int debounce_cycles = 8;
    localparam int debounce_width  = $clog2(debounce_cycles);

    typedef logic [debounce_width-1:0] debounce_cnt_t;

    // lamp test bytes on the upper half of the pages
    localparam int pattern_count = 8;

    localparam logic [0:pattern_count-1][7:0] pattern_bytes = {
        8'h0F,  // page 8
        8'hF0,
        8'h0F,
        8'hAA,
        8'h55,
        8'hF0,
        8'h0F,
        8'hFF   // page 15
    };

endpackage

// ==== hdl/btn_debounce.sv ====
`timescale 1ns/1ps

module btn_debounce (
    input  logic       sys_clk,
    input  logic       rst_n,
    input  logic [1:0] btn,         // bit 0 up, bit 1 down
    output logic       up_pulse,
    output logic       down_pulse
);

    logic [1:0] sync_a;
    logic [1:0] sync_b;
    logic [1:0] level;              // accepted button level
    logic [1:0] pulse;

    panel_pkg::debounce_cnt_t [1:0] stable_cnt;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            sync_a     <= '0;
            sync_b     <= '0;
            level      <= '0;
            stable_cnt <= '0;
            pulse      <= '0;
        end else begin
            // two flop synchronizer
            sync_a <= btn;
            sync_b <= sync_a;

            for (int i = 0; i < 2; i++) begin
                pulse[i] <= 1'b0;
                if (sync_b[i] == level[i]) begin
                    stable_cnt[i] <= '0;    // bounce back, start over
                end else if (stable_cnt[i] ==
                             panel_pkg::debounce_cnt_t'(panel_pkg::debounce_cycles - 1)) begin
                    level[i]      <= sync_b[i];
                    stable_cnt[i] <= '0;
                    pulse[i]      <= sync_b[i];   // only on the rise
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign up_pulse   = pulse[0];
    assign down_pulse = pulse[1];

endmodule

// ==== hdl/region_decoder.sv ====
`timescale 1ns/1ps

module region_decoder (
    input  logic                                   sys_clk,
    input  logic                                   rst_n,
    input  logic                                   access_strobe,
    input  logic [bus_map_pkg::addr_width-1:0]     access_addr,
    input  logic                                   access_write,
    output bus_map_pkg::count_t [bus_map_pkg::region_count-1:0] hit_counts,
    output bus_map_pkg::count_t                    miss_count,
    output bus_map_pkg::count_t                    write_count,
    output bus_map_pkg::count_t                    read_count,
    output bus_map_pkg::region_t                   last_region
);

    logic [bus_map_pkg::region_count-1:0] in_window;
    bus_map_pkg::region_t                 region_code;

    // window compare against every start/end pair
    always_comb begin
        for (int r = 0; r < bus_map_pkg::region_count; r++) begin
            in_window[r] = (access_addr >= bus_map_pkg::start_addr[r]) &&
                           (access_addr <= bus_map_pkg::end_addr[r]);
        end
    end

    // lowest matching window wins, otherwise a miss
    always_comb begin
        region_code = bus_map_pkg::miss_code;
        for (int r = bus_map_pkg::region_count - 1; r >= 0; r--) begin
            if (in_window[r]) begin
                region_code = bus_map_pkg::region_t'(r);
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            hit_counts  <= '0;
            miss_count  <= '0;
            write_count <= '0;
            read_count  <= '0;
            last_region <= '0;
        end else if (access_strobe) begin
            if (region_code == bus_map_pkg::miss_code) begin
                miss_count <= miss_count + 1'b1;
            end

            for (int r = 0; r < bus_map_pkg::region_count; r++) begin
                if (region_code == bus_map_pkg::region_t'(r)) begin
                    hit_counts[r] <= hit_counts[r] + 1'b1;
                end
            end

            if (access_write) begin
                write_count <= write_count + 1'b1;
            end else begin
                read_count <= read_count + 1'b1;
            end

            last_region <= region_code;
        end
    end

endmodule

// ==== hdl/status_panel.sv ====
`timescale 1ns/1ps

module status_panel (
    input  logic                                   sys_clk,
    input  logic                                   rst_n,
    input  logic                                   up_pulse,
    input  logic                                   down_pulse,
    input  bus_map_pkg::count_t [bus_map_pkg::region_count-1:0] hit_counts,
    input  bus_map_pkg::count_t                    miss_count,
    input  bus_map_pkg::count_t                    write_count,
    input  bus_map_pkg::count_t                    read_count,
    input  bus_map_pkg::region_t                   last_region,
    output panel_pkg::led_byte_t                   led8,
    output panel_pkg::page_t                       led4
);

    panel_pkg::page_t page;
    panel_pkg::page_t page_next;

    panel_pkg::led_byte_t [panel_pkg::page_count-1:0] status_bytes;

    // page stepping, both buttons at once cancel
    always_comb begin
        case ({down_pulse, up_pulse})
            2'b01:   page_next = page + 1'b1;
            2'b10:   page_next = page - 1'b1;
            default: page_next = page;
        endcase
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            page <= '0;
        end else begin
            page <= page_next;
        end
    end

    // page map
    always_comb begin
        for (int r = 0; r < bus_map_pkg::region_count; r++) begin
            status_bytes[r] = hit_counts[r];
        end

        status_bytes[4] = miss_count;
        status_bytes[5] = panel_pkg::led_byte_t'(last_region);
        status_bytes[6] = write_count;
        status_bytes[7] = read_count;

        // lamp test on the upper pages
        for (int p = 0; p < panel_pkg::pattern_count; p++) begin
            status_bytes[panel_pkg::page_count - panel_pkg::pattern_count + p] =
                panel_pkg::pattern_bytes[p];
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            led8 <= '1;             // all lamps dark
            led4 <= '0;
        end else begin
            led8 <= ~status_bytes[page];    // active low
            led4 <= page;
        end
    end

endmodule

// ==== hdl/bus_monitor_top.sv ====
`timescale 1ns/1ps

module bus_monitor_top (
    input  logic                               sys_clk,
    input  logic                               rst_n,
    input  logic                               access_strobe,
    input  logic [bus_map_pkg::addr_width-1:0] access_addr,
    input  logic                               access_write,
    input  logic [1:0]                         btn,
    output panel_pkg::led_byte_t               led8,
    output panel_pkg::page_t                   led4
);

    logic up_pulse;
    logic down_pulse;

    bus_map_pkg::count_t [bus_map_pkg::region_count-1:0] hit_counts;
    bus_map_pkg::count_t                                 miss_count;
    bus_map_pkg::count_t                                 write_count;
    bus_map_pkg::count_t                                 read_count;
    bus_map_pkg::region_t                                last_region;

    btn_debounce u_btn_debounce (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .btn        (btn),
        .up_pulse   (up_pulse),
        .down_pulse (down_pulse)
    );

    region_decoder u_region_decoder (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .access_strobe (access_strobe),
        .access_addr   (access_addr),
        .access_write  (access_write),
        .hit_counts    (hit_counts),
        .miss_count    (miss_count),
        .write_count   (write_count),
        .read_count    (read_count),
        .last_region   (last_region)
    );

    status_panel u_status_panel (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .up_pulse    (up_pulse),
        .down_pulse  (down_pulse),
        .hit_counts  (hit_counts),
        .miss_count  (miss_count),
        .write_count (write_count),
        .read_count  (read_count),
        .last_region (last_region),
        .led8        (led8),
        .led4        (led4)
    );

endmodule

// ==== testbench/bus_monitor_chk.sv ====
`timescale 1ns/1ps

module bus_monitor_chk (
    input logic                                                sys_clk,
    input logic                                                rst_n,
    input logic                                                access_strobe,
    input logic [bus_map_pkg::addr_width-1:0]                  access_addr,
    input panel_pkg::page_t                                    led4,
    input bus_map_pkg::region_t                                last_region,
    input bus_map_pkg::count_t [bus_map_pkg::region_count-1:0] hit_counts,
    input bus_map_pkg::count_t                                 miss_count
);

    panel_pkg::page_t     led4_prev;
    panel_pkg::page_t     led4_step;
    bus_map_pkg::count_t  access_sum;   // wraps with the counters
    bus_map_pkg::count_t  access_sum_prev;
    logic                 strobe_prev;
    bus_map_pkg::region_t last_expected;    // decode of the last strobed address
    int                   failures = 0;

    always_comb begin
        access_sum = miss_count;
        for (int r = 0; r < bus_map_pkg::region_count; r++) begin
            access_sum = access_sum + hit_counts[r];
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            led4_prev       <= '0;
            access_sum_prev <= '0;
            strobe_prev     <= 1'b0;
            last_expected   <= '0;
        end else begin
            led4_prev       <= led4;
            access_sum_prev <= access_sum;
            strobe_prev     <= access_strobe;
            if (access_strobe) begin
                // 256 MB windows from zero, anything from 0x4000_0000 up misses
                last_expected <= (access_addr[31:30] == 2'b00) ?
                                 {1'b0, access_addr[29:28]} : bus_map_pkg::miss_code;
            end
        end
    end

    assign led4_step = led4 - led4_prev;

    assert property (@(posedge sys_clk) disable iff (!rst_n)
        led4_step == 4'd0 || led4_step == 4'd1 || led4_step == 4'd15)
        else begin
            $error("led4 jumped from %0d to %0d", led4_prev, led4);
            failures++;
        end

    assert property (@(posedge sys_clk) disable iff (!rst_n)
        last_region <= bus_map_pkg::miss_code && last_region == last_expected)
        else begin
            $error("last_region %0d, expected %0d", last_region, last_expected);
            failures++;
        end

    assert property (@(posedge sys_clk) disable iff (!rst_n)
        (access_sum != access_sum_prev) |-> strobe_prev)
        else begin
            $error("access counters moved without a strobe");
            failures++;
        end

endmodule

bind bus_monitor_top bus_monitor_chk u_bus_monitor_chk (
    .sys_clk       (sys_clk),
    .rst_n         (rst_n),
    .access_strobe (access_strobe),
    .access_addr   (access_addr),
    .led4          (led4),
    .last_region   (last_region),
    .hit_counts    (hit_counts),
    .miss_count    (miss_count)
);

// ==== testbench/tb_bus_monitor.sv ====
`timescale 1ns/1ps

module tb_bus_monitor;

    localparam int page_timeout = 200;  // cycles to wait for led4

    logic                                sys_clk;
    logic                                rst_n;
    logic                                access_strobe;
    logic [bus_map_pkg::addr_width-1:0]  access_addr;
    logic                                access_write;
    logic [1:0]                          btn;
    panel_pkg::led_byte_t                led8;
    panel_pkg::page_t                    led4;

    // reference model state
    bus_map_pkg::count_t  model_hits [bus_map_pkg::region_count];
    bus_map_pkg::count_t  model_miss;
    bus_map_pkg::count_t  model_writes;
    bus_map_pkg::count_t  model_reads;
    bus_map_pkg::region_t model_last;
    panel_pkg::page_t     model_page;

    logic [31:0] rng_state;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    bus_monitor_top dut (
        .sys_clk       (sys_clk),
        .rst_n         (rst_n),
        .access_strobe (access_strobe),
        .access_addr   (access_addr),
        .access_write  (access_write),
        .btn           (btn),
        .led8          (led8),
        .led4          (led4)
    );

    initial begin
        sys_clk = 1'b0;
        forever #10 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // windows are 256 MB each, starting at zero
    function automatic bus_map_pkg::region_t expected_region(input logic [31:0] addr);
        if (addr < 32'h4000_0000) begin
            return {1'b0, addr[29:28]};
        end
        return bus_map_pkg::miss_code;
    endfunction

    function automatic panel_pkg::led_byte_t model_byte(input panel_pkg::page_t pg);
        case (pg)
            4'd0, 4'd1, 4'd2, 4'd3: return model_hits[pg[1:0]];
            4'd4:    return model_miss;
            4'd5:    return {5'b0, model_last};
            4'd6:    return model_writes;
            4'd7:    return model_reads;
            default: return panel_pkg::pattern_bytes[pg[2:0]];  // lamp test
        endcase
    endfunction

    task automatic send_access(input logic [31:0] addr, input logic is_write);
        bus_map_pkg::region_t code;
        code = expected_region(addr);
        @(posedge sys_clk);
        access_strobe <= 1'b1;
        access_addr   <= addr;
        access_write  <= is_write;
        @(posedge sys_clk);
        access_strobe <= 1'b0;
        if (code == bus_map_pkg::miss_code) begin
            model_miss = model_miss + 8'd1;
        end else begin
            model_hits[code[1:0]] = model_hits[code[1:0]] + 8'd1;
        end
        if (is_write) begin
            model_writes = model_writes + 8'd1;
        end else begin
            model_reads = model_reads + 8'd1;
        end
        model_last = code;
    endtask

    // hold 30 cycles, release 30 cycles
    task automatic press_button(input logic [1:0] which);
        @(posedge sys_clk);
        btn <= which;
        repeat (30) @(posedge sys_clk);
        btn <= 2'b00;
        repeat (30) @(posedge sys_clk);
        case (which)
            2'b01:   model_page = model_page + 4'd1;
            2'b10:   model_page = model_page - 4'd1;
            default: model_page = model_page;
        endcase
    endtask

    task automatic goto_page(input panel_pkg::page_t target);
        panel_pkg::page_t up_steps;
        up_steps = target - model_page;
        if (up_steps <= 4'd8) begin
            repeat (int'(up_steps)) press_button(2'b01);
        end else begin
            repeat (16 - int'(up_steps)) press_button(2'b10);
        end
    endtask

    task automatic wait_page(output bit reached);
        int cycles;
        reached = 1'b0;
        for (cycles = 0; cycles < page_timeout && !reached; cycles++) begin
            @(negedge sys_clk);
            if (led4 == model_page) reached = 1'b1;
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        assert (actual == expected) else begin
            $display("FAIL %s expected 0x%02h actual 0x%02h", name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_page(input string name, input panel_pkg::page_t pg);
        bit reached;
        goto_page(pg);
        wait_page(reached);
        if (!reached) begin
            $display("timeout in %s, led4 never showed page %0d", name, pg);
            test_errors++;
        end else begin
            check_byte(name, ~model_byte(pg), led8);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        logic [31:0]      addr;
        panel_pkg::page_t page_before;

        rst_n         = 1'b0;
        access_strobe = 1'b0;
        access_addr   = '0;
        access_write  = 1'b0;
        btn           = 2'b00;
        rng_state     = 32'd94426;
        model_miss    = '0;
        model_writes  = '0;
        model_reads   = '0;
        model_last    = '0;
        model_page    = '0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        for (int r = 0; r < bus_map_pkg::region_count; r++) model_hits[r] = '0;

        repeat (2) @(posedge sys_clk);
        rst_n <= 1'b1;

        @(negedge sys_clk);
        check_byte("reset_led4", 8'h00, {4'b0, led4});
        check_byte("reset_led8", 8'hFF, led8);
        finish_test("reset_state");

        for (int i = 0; i < 200; i++) begin
            addr = next_random() & 32'h3FFF_FFFF;
            send_access(addr, next_random() >= 32'h8000_0000);
        end
        for (int r = 0; r < bus_map_pkg::region_count; r++) begin
            check_page($sformatf("hits_region%0d", r), panel_pkg::page_t'(r));
        end
        finish_test("region_hits");

        // about half of these land above the map
        for (int i = 0; i < 80; i++) begin
            addr = next_random();
            if (next_random() >> 31) addr = addr | 32'h4000_0000;
            else addr = addr & 32'h3FFF_FFFF;
            send_access(addr, next_random() >= 32'h8000_0000);
        end
        check_page("miss_count", 4'd4);
        check_page("last_region", 4'd5);
        finish_test("misses_last_region");

        check_page("write_count", 4'd6);
        check_page("read_count", 4'd7);
        finish_test("direction_counts");

        goto_page(4'd0);
        for (int i = 0; i < 16; i++) begin
            press_button(2'b01);
            check_page($sformatf("step_up_page%0d", model_page), model_page);
        end
        check_byte("wrap_to_zero", 8'h00, {4'b0, led4});
        press_button(2'b10);
        check_page("down_from_zero", model_page);
        check_byte("down_page", 8'h0F, {4'b0, led4});
        finish_test("page_stepping");

        page_before = model_page;
        press_button(2'b11);
        @(negedge sys_clk);
        check_byte("both_buttons_page", {4'b0, page_before}, {4'b0, led4});
        check_byte("both_buttons_led8", ~model_byte(page_before), led8);
        finish_test("simultaneous_press");

        // concurrent checks bound into the DUT
        assert (dut.u_bus_monitor_chk.failures == 0) else begin
            $display("bound assertions failed %0d times", dut.u_bus_monitor_chk.failures);
            test_errors++;
        end
        finish_test("bound_assertions");

        $display("summary: %0d tests, %0d passed, %0d failed",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/bus_map_pkg.sv
hdl/panel_pkg.sv
hdl/btn_debounce.sv
hdl/region_decoder.sv
hdl/status_panel.sv
hdl/bus_monitor_top.sv
testbench/bus_monitor_chk.sv
testbench/tb_bus_monitor.sv

// ==== Makefile ====
# Verilator build and run for the bus monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_bus_monitor
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
